// ==== all.f ====
hdl/ampduDelimPkg.sv
hdl/delimiterCtrlFsm.sv
hdl/txByteSequencer.sv
hdl/delimiterCrc8.sv
hdl/delimiterFormatter.sv
hdl/paddingCounter.sv
hdl/formatAmpduDelimiter.sv
verification/tbClockGen.sv
verification/formatAmpduDelimiter_assert.sv
verification/tbFormatAmpduDelimiter.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it into sim.log and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tbFormatAmpduDelimiter \
  -f all.f -Mdir obj_dir -o simFormatAmpduDelimiter > build.log 2>&1 \
  && ./obj_dir/simFormatAmpduDelimiter > sim.log 2>&1 \
  && grep -q "All checks passed" sim.log \
  && echo "Simulation passed, see sim.log" \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// ==== verification/tbFormatAmpduDelimiter.sv ====
// Directed testbench for the A-MPDU delimiter formatter, used as the simulation top
`timescale 1ns/100ps

module tbFormatAmpduDelimiter;

  ////////////////////
  // DUT signals
  ////////////////////

  logic                      macCoreTxClk;
  logic                      macCoreClkHardRst_n;
  logic                      macCoreTxClkSoftRst_n;
  logic                      aMPDUPaddingStart_p;
  logic                      aMPDUDelimiterStart_p;
  logic                      addBlankDelimiter;
  logic                      aMPDUDelimiterDone_p;
  logic                      aMPDUPaddingDone_p;
  ampduDelimPkg::frameLenT   MPDUFrameLengthTx;
  ampduDelimPkg::blankCountT nBlankMDelimiters;
  logic                      txSingleVHTMPDU;
  ampduDelimPkg::formatModT  formatModTx;
  logic                      mpIfTxFifoFull;
  ampduDelimPkg::byteT       aMPDUDelimiterData;
  logic                      aMPDUDelimiterWriteEn;

  // Monitor state written only by the monitor
  ampduDelimPkg::byteT wrBytes[$];
  int                  cycleCnt;
  int                  startCyc;
  int                  doneCyc;
  int                  doneBytes;
  int                  stallCnt;
  int                  delimDoneCnt;
  int                  padDoneCnt;
  int                  monChkCnt;
  int                  monErrCnt;
  logic                reqOpen = 1'b0;

  // Test side
  ampduDelimPkg::byteT expBytes[$];
  int                  wrBase;
  int                  checkCnt;
  int                  errCnt;
  logic                stallEn;

  tbClockGen uClkGen
  (
    .macCoreTxClk        (macCoreTxClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n)
  );

  formatAmpduDelimiter dut0
  (
    .macCoreTxClk          (macCoreTxClk),
    .macCoreClkHardRst_n   (macCoreClkHardRst_n),
    .macCoreTxClkSoftRst_n (macCoreTxClkSoftRst_n),
    .aMPDUPaddingStart_p   (aMPDUPaddingStart_p),
    .aMPDUDelimiterStart_p (aMPDUDelimiterStart_p),
    .addBlankDelimiter     (addBlankDelimiter),
    .aMPDUDelimiterDone_p  (aMPDUDelimiterDone_p),
    .aMPDUPaddingDone_p    (aMPDUPaddingDone_p),
    .MPDUFrameLengthTx     (MPDUFrameLengthTx),
    .nBlankMDelimiters     (nBlankMDelimiters),
    .txSingleVHTMPDU       (txSingleVHTMPDU),
    .formatModTx           (formatModTx),
    .mpIfTxFifoFull        (mpIfTxFifoFull),
    .aMPDUDelimiterData    (aMPDUDelimiterData),
    .aMPDUDelimiterWriteEn (aMPDUDelimiterWriteEn)
  );

  // Random FIFO-full stalls on the falling edge while enabled
  initial
  begin
    mpIfTxFifoFull = 1'b0;
    forever
    begin
      @(negedge macCoreTxClk);
      mpIfTxFifoFull = stallEn && ($urandom_range(2, 0) == 0);
    end
  end

  ////////////////////
  // Monitor
  ////////////////////

  // Collects written bytes, done pulses and stall cycles on the rising edge
  always @(posedge macCoreTxClk)
  begin
    if (reqOpen && mpIfTxFifoFull)
      stallCnt++;
    if (aMPDUDelimiterWriteEn)
    begin
      monChkCnt++;
      noWriteWhileFull: assert (!mpIfTxFifoFull)
      else
      begin
        monErrCnt++;
        $display("write enable high at %0t while the FIFO is full", $time);
      end
      wrBytes.push_back(aMPDUDelimiterData);
    end
    if (aMPDUDelimiterDone_p || aMPDUPaddingDone_p)
    begin
      doneCyc   = cycleCnt;
      doneBytes = wrBytes.size();
      reqOpen   = 1'b0;
    end
    if (aMPDUDelimiterDone_p)
      delimDoneCnt++;
    if (aMPDUPaddingDone_p)
      padDoneCnt++;
    if (aMPDUDelimiterStart_p || aMPDUPaddingStart_p)
    begin
      startCyc = cycleCnt;
      stallCnt = 0;
      reqOpen  = 1'b1;
    end
    if (!macCoreTxClkSoftRst_n)
      reqOpen = 1'b0;
    cycleCnt++;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Serial CRC-8 over x8+x2+x+1 with preset all ones and bits taken LSB first from byte 0
  // Result is complemented and sent from the top register bit down
  function automatic ampduDelimPkg::byteT crcRef(input ampduDelimPkg::byteT b0,
                                                 input ampduDelimPkg::byteT b1);
    logic [15:0]         bits;
    ampduDelimPkg::byteT c;
    ampduDelimPkg::byteT r;
    logic                fb;
    bits = {b1, b0};
    c    = 8'hFF;
    for (int i = 0; i < 16; i++)
    begin
      fb = c[7] ^ bits[i];
      c  = {c[6:0], 1'b0};
      if (fb)
        c = c ^ 8'h07;
    end
    for (int i = 0; i < 8; i++)
      r[i] = ~c[7-i];
    return r;
  endfunction

  // Appends the four expected bytes of one delimiter
  function automatic void pushDelimiter(input logic [13:0] len, input logic vht,
                                        input logic single);
    ampduDelimPkg::byteT b0;
    ampduDelimPkg::byteT b1;
    if (vht)
      b0 = {len[3:0], len[13:12], 1'b0, single};
    else
      b0 = {len[3:0], 4'b0000};
    b1 = len[11:4];
    expBytes.push_back(b0);
    expBytes.push_back(b1);
    expBytes.push_back(crcRef(b0, b1));
    expBytes.push_back(8'h4E);
  endfunction

  function automatic ampduDelimPkg::formatModT pickNonVhtFormat();
    logic [31:0] rnd;
    rnd = $urandom;
    if (rnd[2:0] == ampduDelimPkg::FORMAT_VHT)
      return 3'b000;
    return rnd[2:0];
  endfunction

  function automatic int totalErrors();
    return errCnt + monErrCnt;
  endfunction

  ////////////////////
  // Helpers
  ////////////////////

  task automatic checkEqual(input int got, input int exp, input string what);
    checkCnt++;
    valueMatch: assert (got == exp)
    else
    begin
      errCnt++;
      $display("mismatch at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic idleCycles(input int n);
    for (int i = 0; i < n; i++)
      @(negedge macCoreTxClk);
  endtask

  // Waits for the next delimiter or padding done pulse
  task automatic waitDone(input logic pad, input int prevCnt, input string name);
    int cyc;
    cyc = 0;
    while (((pad ? padDoneCnt : delimDoneCnt) == prevCnt) && (cyc < 300))
    begin
      @(negedge macCoreTxClk);
      cyc++;
    end
    checkCnt++;
    doneArrived: assert ((pad ? padDoneCnt : delimDoneCnt) != prevCnt)
    else
    begin
      errCnt++;
      $display("%s: timed out waiting for the done pulse", name);
    end
  endtask

  // Count, done position, latency and content of the last run
  task automatic checkStream(input string name);
    int nWr;
    nWr = wrBytes.size() - wrBase;
    checkEqual(nWr, expBytes.size(), $sformatf("%s: bytes written", name));
    checkEqual(doneBytes - wrBase, expBytes.size(), $sformatf("%s: bytes at done", name));
    checkEqual(doneCyc - startCyc, expBytes.size() + stallCnt,
               $sformatf("%s: cycles from start to done", name));
    for (int i = 0; (i < nWr) && (i < expBytes.size()); i++)
      checkEqual(int'(wrBytes[wrBase + i]), int'(expBytes[i]),
                 $sformatf("%s: byte %0d", name, i));
  endtask

  task automatic sendDelimiter(input ampduDelimPkg::frameLenT len,
                               input ampduDelimPkg::formatModT fmt, input logic single,
                               input int nBlank, input logic stall, input string name);
    int prevDone;
    expBytes.delete();
    for (int i = 0; i < nBlank; i++)
      pushDelimiter(14'd0, 1'b0, 1'b0);
    pushDelimiter(len[13:0], fmt == ampduDelimPkg::FORMAT_VHT, single);
    wrBase                = wrBytes.size();
    prevDone              = delimDoneCnt;
    stallEn               = stall;
    MPDUFrameLengthTx     = len;
    formatModTx           = fmt;
    txSingleVHTMPDU       = single;
    addBlankDelimiter     = (nBlank > 0);
    nBlankMDelimiters     = nBlank[9:0];
    aMPDUDelimiterStart_p = 1'b1;
    @(negedge macCoreTxClk);
    aMPDUDelimiterStart_p = 1'b0;
    waitDone(1'b0, prevDone, name);
    stallEn = 1'b0;
    idleCycles(3);
    checkStream(name);
  endtask

  // Zero bytes up to the next multiple of four
  task automatic sendPadding(input ampduDelimPkg::frameLenT len, input logic stall,
                             input string name);
    int prevDone;
    expBytes.delete();
    for (int i = 0; i < 4 - int'(len[1:0]); i++)
      expBytes.push_back(8'h00);
    wrBase              = wrBytes.size();
    prevDone            = padDoneCnt;
    stallEn             = stall;
    MPDUFrameLengthTx   = len;
    aMPDUPaddingStart_p = 1'b1;
    @(negedge macCoreTxClk);
    aMPDUPaddingStart_p = 1'b0;
    waitDone(1'b1, prevDone, name);
    stallEn = 1'b0;
    idleCycles(3);
    checkStream(name);
  endtask

  task automatic reportTest(input string name, input int errStart);
    $display("%s test finished with %0d errors", name, totalErrors() - errStart);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic testPlainDelimiter();
    int          errStart;
    logic [31:0] rnd;
    errStart = totalErrors();
    for (int k = 0; k < 3; k++)
    begin
      rnd = $urandom;
      sendDelimiter(rnd[15:0], pickNonVhtFormat(), rnd[16], 0, 1'b0, "plain delimiter");
    end
    reportTest("plain delimiter", errStart);
  endtask

  task automatic testVhtDelimiter();
    int          errStart;
    logic [31:0] rnd;
    errStart = totalErrors();
    for (int s = 0; s < 2; s++)
    begin
      rnd = $urandom;
      sendDelimiter(rnd[15:0], ampduDelimPkg::FORMAT_VHT, s[0], 0, 1'b0,
                    $sformatf("VHT delimiter single %0d", s));
    end
    reportTest("VHT delimiter", errStart);
  endtask

  task automatic testBlankDelimiters();
    int          errStart;
    logic [31:0] rnd;
    errStart = totalErrors();
    for (int n = 1; n < 6; n++)
    begin
      rnd = $urandom;
      sendDelimiter(rnd[15:0], pickNonVhtFormat(), 1'b0, n, 1'b0,
                    $sformatf("%0d blank delimiters", n));
    end
    reportTest("blank delimiters", errStart);
  endtask

  task automatic testPadding();
    int          errStart;
    logic [31:0] rnd;
    errStart = totalErrors();
    for (int r = 1; r < 4; r++)
    begin
      rnd = $urandom;
      sendPadding({rnd[15:2], r[1:0]}, 1'b0, $sformatf("padding residue %0d", r));
    end
    reportTest("padding", errStart);
  endtask

  // Same runs as above with random FIFO-full cycles
  task automatic testBackPressure();
    int          errStart;
    logic [31:0] rnd;
    errStart = totalErrors();
    rnd = $urandom;
    sendDelimiter(rnd[15:0], pickNonVhtFormat(), 1'b0, 0, 1'b1, "stalled plain delimiter");
    for (int n = 2; n < 5; n += 2)
    begin
      rnd = $urandom;
      sendDelimiter(rnd[15:0], pickNonVhtFormat(), 1'b0, n, 1'b1,
                    $sformatf("stalled %0d blank delimiters", n));
    end
    for (int r = 1; r < 4; r++)
    begin
      rnd = $urandom;
      sendPadding({rnd[15:2], r[1:0]}, 1'b1, $sformatf("stalled padding residue %0d", r));
    end
    reportTest("back-pressure", errStart);
  endtask

  task automatic testSoftReset();
    int          errStart;
    int          cyc;
    int          prevDone;
    int          sizeAfter;
    logic [31:0] rnd;
    errStart = totalErrors();
    rnd      = $urandom;
    wrBase   = wrBytes.size();
    prevDone = delimDoneCnt;
    // Two blank delimiters first so the run is long enough to cut
    MPDUFrameLengthTx     = rnd[15:0];
    formatModTx           = 3'b000;
    addBlankDelimiter     = 1'b1;
    nBlankMDelimiters     = 10'd2;
    aMPDUDelimiterStart_p = 1'b1;
    @(negedge macCoreTxClk);
    aMPDUDelimiterStart_p = 1'b0;
    cyc = 0;
    while ((wrBytes.size() - wrBase < 2) && (cyc < 50))
    begin
      @(negedge macCoreTxClk);
      cyc++;
    end
    checkCnt++;
    bytesStarted: assert (wrBytes.size() - wrBase >= 2)
    else
    begin
      errCnt++;
      $display("soft reset: timed out waiting for the first delimiter bytes");
    end
    // One cycle pulse in the middle of the delimiter
    macCoreTxClkSoftRst_n = 1'b0;
    @(negedge macCoreTxClk);
    macCoreTxClkSoftRst_n = 1'b1;
    sizeAfter = wrBytes.size();
    idleCycles(8);
    checkEqual(wrBytes.size(), sizeAfter, "soft reset: bytes written after the reset");
    checkEqual(delimDoneCnt, prevDone, "soft reset: done pulses after the reset");
    rnd = $urandom;
    sendDelimiter(rnd[15:0], pickNonVhtFormat(), 1'b0, 0, 1'b0, "delimiter after soft reset");
    reportTest("soft reset", errStart);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial
  begin
    int cyc;
    void'($urandom(32'h3faf0245));
    stallEn               = 1'b0;
    macCoreTxClkSoftRst_n = 1'b1;
    aMPDUPaddingStart_p   = 1'b0;
    aMPDUDelimiterStart_p = 1'b0;
    addBlankDelimiter     = 1'b0;
    MPDUFrameLengthTx     = '0;
    nBlankMDelimiters     = '0;
    txSingleVHTMPDU       = 1'b0;
    formatModTx           = '0;
    cyc = 0;
    while (!macCoreClkHardRst_n && (cyc < 40))
    begin
      @(negedge macCoreTxClk);
      cyc++;
    end
    checkCnt++;
    resetReleased: assert (macCoreClkHardRst_n)
    else
    begin
      errCnt++;
      $display("hard reset was never released");
    end
    idleCycles(2);
    // Outputs quiet after reset
    checkEqual(int'(aMPDUDelimiterWriteEn), 0, "write enable after reset");
    checkEqual(int'(aMPDUDelimiterDone_p), 0, "delimiter done after reset");
    checkEqual(int'(aMPDUPaddingDone_p), 0, "padding done after reset");
    testPlainDelimiter();
    testVhtDelimiter();
    testBlankDelimiters();
    testPadding();
    testBackPressure();
    testSoftReset();
    $display("Checks run: %0d, failed: %0d", checkCnt + monChkCnt, totalErrors());
    if (totalErrors() == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// ==== verification/formatAmpduDelimiter_assert.sv ====
// Port-level protocol assertions for the delimiter formatter, bound into every DUT instance
`timescale 1ns/100ps

module formatAmpduDelimiter_assert
(
  input logic macCoreTxClk,
  input logic macCoreClkHardRst_n,
  input logic macCoreTxClkSoftRst_n,
  input logic aMPDUPaddingStart_p,
  input logic aMPDUDelimiterStart_p,
  input logic aMPDUDelimiterDone_p,
  input logic aMPDUPaddingDone_p,
  input logic mpIfTxFifoFull,
  input logic aMPDUDelimiterWriteEn
);

  // Open from the cycle after a start until its done pulse
  logic reqOpen;

  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      reqOpen <= 1'b0;
    else if (!macCoreTxClkSoftRst_n || aMPDUDelimiterDone_p || aMPDUPaddingDone_p)
      reqOpen <= 1'b0;
    else if (aMPDUDelimiterStart_p || aMPDUPaddingStart_p)
      reqOpen <= 1'b1;
  end

  ////////////////////
  // FIFO side
  ////////////////////

  // A full FIFO blocks every write
  noWriteWhenFull: assert property (@(posedge macCoreTxClk) disable iff (!macCoreClkHardRst_n)
    !(aMPDUDelimiterWriteEn && mpIfTxFifoFull))
    else $error("write enable high while the FIFO is full");

  // Writes only inside a request
  writeInRequest: assert property (@(posedge macCoreTxClk) disable iff (!macCoreClkHardRst_n)
    aMPDUDelimiterWriteEn |-> reqOpen)
    else $error("write outside of a delimiter or padding request");

  ////////////////////
  // Done pulses
  ////////////////////

  delimDoneSingle: assert property (@(posedge macCoreTxClk) disable iff (!macCoreClkHardRst_n)
    aMPDUDelimiterDone_p |=> !aMPDUDelimiterDone_p)
    else $error("delimiter done pulse longer than one cycle");

  padDoneSingle: assert property (@(posedge macCoreTxClk) disable iff (!macCoreClkHardRst_n)
    aMPDUPaddingDone_p |=> !aMPDUPaddingDone_p)
    else $error("padding done pulse longer than one cycle");

  doneExclusive: assert property (@(posedge macCoreTxClk) disable iff (!macCoreClkHardRst_n)
    !(aMPDUDelimiterDone_p && aMPDUPaddingDone_p))
    else $error("delimiter and padding done pulses in the same cycle");

endmodule

bind formatAmpduDelimiter formatAmpduDelimiter_assert uProtocolAssert
(
  .macCoreTxClk          (macCoreTxClk),
  .macCoreClkHardRst_n   (macCoreClkHardRst_n),
  .macCoreTxClkSoftRst_n (macCoreTxClkSoftRst_n),
  .aMPDUPaddingStart_p   (aMPDUPaddingStart_p),
  .aMPDUDelimiterStart_p (aMPDUDelimiterStart_p),
  .aMPDUDelimiterDone_p  (aMPDUDelimiterDone_p),
  .aMPDUPaddingDone_p    (aMPDUPaddingDone_p),
  .mpIfTxFifoFull        (mpIfTxFifoFull),
  .aMPDUDelimiterWriteEn (aMPDUDelimiterWriteEn)
);

// ==== verification/tbClockGen.sv ====
// Testbench clock and hard reset source, instantiated once by the testbench top
`timescale 1ns/100ps

module tbClockGen
(
  output logic macCoreTxClk,
  output logic macCoreClkHardRst_n
);

  // 20 ns period
  initial
  begin
    macCoreTxClk = 1'b0;
    forever #10 macCoreTxClk = ~macCoreTxClk;
  end

  // Reset held for 10 cycles, released on a falling edge
  initial
  begin
    macCoreClkHardRst_n = 1'b0;
    repeat (10) @(posedge macCoreTxClk);
    @(negedge macCoreTxClk);
    macCoreClkHardRst_n = 1'b1;
  end

endmodule

// ==== hdl/formatAmpduDelimiter.sv ====
// Top of the A-MPDU delimiter formatter, placed between the transmit controller and the FIFO
`timescale 1ns/100ps

module formatAmpduDelimiter
(
  // Clock and resets
  input  logic                    macCoreTxClk,
  input  logic                    macCoreClkHardRst_n,
  input  logic                    macCoreTxClkSoftRst_n,

  // Transmit controller handshake
  input  logic                    aMPDUPaddingStart_p,
  input  logic                    aMPDUDelimiterStart_p,
  input  logic                    addBlankDelimiter,
  output logic                    aMPDUDelimiterDone_p,
  output logic                    aMPDUPaddingDone_p,

  // Parameter cache, stable from start to done
  input  ampduDelimPkg::frameLenT   MPDUFrameLengthTx,
  input  ampduDelimPkg::blankCountT nBlankMDelimiters,
  input  logic                      txSingleVHTMPDU,
  input  ampduDelimPkg::formatModT  formatModTx,

  // MAC-PHY FIFO side
  input  logic                    mpIfTxFifoFull,
  output ampduDelimPkg::byteT     aMPDUDelimiterData,
  output logic                    aMPDUDelimiterWriteEn
);

  ////////////////////
  // Internal wires
  ////////////////////

  // Controller state shared by formatter and padding
  ampduDelimPkg::delimFsmT fsmState;
  // Byte position from the sequencer
  ampduDelimPkg::byteIdxT  byteIdx;
  // Request in progress
  logic                    seqActive;
  // Unstalled signature byte
  logic                    delimiterSent;
  // Unstalled last pad byte
  logic                    paddingSent;
  // Inverted reversed CRC for byte 2
  ampduDelimPkg::byteT     crcByte;

  ////////////////////
  // Instances
  ////////////////////

  // State machine and blank delimiter count
  delimiterCtrlFsm uCtrlFsm
  (
    .macCoreTxClk          (macCoreTxClk),
    .macCoreClkHardRst_n   (macCoreClkHardRst_n),
    .macCoreTxClkSoftRst_n (macCoreTxClkSoftRst_n),
    .aMPDUDelimiterStart_p (aMPDUDelimiterStart_p),
    .aMPDUPaddingStart_p   (aMPDUPaddingStart_p),
    .addBlankDelimiter     (addBlankDelimiter),
    .nBlankMDelimiters     (nBlankMDelimiters),
    .delimiterSent         (delimiterSent),
    .paddingSent           (paddingSent),
    .fsmState              (fsmState),
    .aMPDUDelimiterDone_p  (aMPDUDelimiterDone_p),
    .aMPDUPaddingDone_p    (aMPDUPaddingDone_p)
  );

  // Byte pacing under FIFO back-pressure
  txByteSequencer uByteSeq
  (
    .macCoreTxClk          (macCoreTxClk),
    .macCoreClkHardRst_n   (macCoreClkHardRst_n),
    .macCoreTxClkSoftRst_n (macCoreTxClkSoftRst_n),
    .aMPDUDelimiterStart_p (aMPDUDelimiterStart_p),
    .aMPDUPaddingStart_p   (aMPDUPaddingStart_p),
    .aMPDUDelimiterDone_p  (aMPDUDelimiterDone_p),
    .aMPDUPaddingDone_p    (aMPDUPaddingDone_p),
    .mpIfTxFifoFull        (mpIfTxFifoFull),
    .byteIdx               (byteIdx),
    .seqActive             (seqActive),
    .delimiterSent         (delimiterSent),
    .aMPDUDelimiterWriteEn (aMPDUDelimiterWriteEn)
  );

  // CRC over bytes 0 and 1, fed back from the formatter
  delimiterCrc8 uCrc8
  (
    .macCoreTxClk          (macCoreTxClk),
    .macCoreClkHardRst_n   (macCoreClkHardRst_n),
    .macCoreTxClkSoftRst_n (macCoreTxClkSoftRst_n),
    .seqActive             (seqActive),
    .byteIdx               (byteIdx),
    .delimiterSent         (delimiterSent),
    .mpIfTxFifoFull        (mpIfTxFifoFull),
    .delimByte             (aMPDUDelimiterData),
    .crcByte               (crcByte)
  );

  // Byte multiplexer
  delimiterFormatter uFormatter
  (
    .fsmState              (fsmState),
    .byteIdx               (byteIdx),
    .MPDUFrameLengthTx     (MPDUFrameLengthTx),
    .formatModTx           (formatModTx),
    .txSingleVHTMPDU       (txSingleVHTMPDU),
    .crcByte               (crcByte),
    .delimByte             (aMPDUDelimiterData)
  );

  // Pad length and end of padding
  paddingCounter uPadCnt
  (
    .macCoreTxClk          (macCoreTxClk),
    .macCoreClkHardRst_n   (macCoreClkHardRst_n),
    .macCoreTxClkSoftRst_n (macCoreTxClkSoftRst_n),
    .fsmState              (fsmState),
    .aMPDUPaddingStart_p   (aMPDUPaddingStart_p),
    .MPDUFrameLengthTx     (MPDUFrameLengthTx),
    .byteIdx               (byteIdx),
    .mpIfTxFifoFull        (mpIfTxFifoFull),
    .paddingSent           (paddingSent)
  );

endmodule

// ==== hdl/paddingCounter.sv ====
// Padding length tracker that flags the last zero byte needed for 4-byte alignment
`timescale 1ns/100ps

module paddingCounter
(
  input  logic                    macCoreTxClk,
  input  logic                    macCoreClkHardRst_n,
  input  logic                    macCoreTxClkSoftRst_n,
  input  ampduDelimPkg::delimFsmT fsmState,
  input  logic                    aMPDUPaddingStart_p,
  input  ampduDelimPkg::frameLenT MPDUFrameLengthTx,
  input  ampduDelimPkg::byteIdxT  byteIdx,
  input  logic                    mpIfTxFifoFull,
  output logic                    paddingSent
);

  // Length modulo four of the previous MPDU
  logic [1:0]             lenMod4;
  // Index of the last pad byte
  ampduDelimPkg::byteIdxT padIdx;

  // Captured at the padding start edge
  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      lenMod4 <= 2'd0;
    else if (!macCoreTxClkSoftRst_n || paddingSent)
      lenMod4 <= 2'd0;
    else if (aMPDUPaddingStart_p && (fsmState != ampduDelimPkg::INSERT_PAD))
      lenMod4 <= MPDUFrameLengthTx[1:0];
  end

  // Residue to last pad index
  // Residue 0 needs no padding and is not requested
  always_comb
  begin
    case (lenMod4)
      2'd1:    padIdx = 2'd2;
      2'd2:    padIdx = 2'd1;
      default: padIdx = 2'd0;
    endcase
  end

  // Last zero byte accepted by the FIFO
  assign paddingSent = (fsmState == ampduDelimPkg::INSERT_PAD) &&
                       (byteIdx == padIdx) && !mpIfTxFifoFull;

endmodule

// ==== hdl/delimiterFormatter.sv ====
// Combinational byte selector building each delimiter byte from length, format and CRC
`timescale 1ns/100ps

module delimiterFormatter
(
  input  ampduDelimPkg::delimFsmT  fsmState,
  input  ampduDelimPkg::byteIdxT   byteIdx,
  input  ampduDelimPkg::frameLenT  MPDUFrameLengthTx,
  input  ampduDelimPkg::formatModT formatModTx,
  input  logic                     txSingleVHTMPDU,
  input  ampduDelimPkg::byteT      crcByte,
  output ampduDelimPkg::byteT      delimByte
);

  // Length carried by the delimiter, zero for blank ones
  logic [13:0] delimLen;
  // VHT byte 0 layout in use
  logic        vhtLayout;
  logic        inDelim;

  assign delimLen  = (fsmState == ampduDelimPkg::INSERT_BLANKDEL) ? 14'd0 :
                     MPDUFrameLengthTx[13:0];
  assign vhtLayout = (fsmState == ampduDelimPkg::INSERT_DEL) &&
                     (formatModTx == ampduDelimPkg::FORMAT_VHT);
  assign inDelim   = (fsmState == ampduDelimPkg::INSERT_BLANKDEL) ||
                     (fsmState == ampduDelimPkg::INSERT_DEL);

  always_comb
  begin
    delimByte = '0;
    // Padding and idle send zero bytes
    if (inDelim)
    begin
      case (byteIdx)
        2'd0:
          if (vhtLayout)
            delimByte = {delimLen[3:0], delimLen[13:12], 1'b0, txSingleVHTMPDU};
          else
            delimByte = {delimLen[3:0], 4'b0000};
        2'd1: delimByte = delimLen[11:4];
        2'd2: delimByte = crcByte;
        default: delimByte = ampduDelimPkg::DEL_SIGNATURE;
      endcase
    end
  end

endmodule

// ==== hdl/delimiterCrc8.sv ====
// Running CRC-8 over the first two delimiter bytes, giving the byte 2 value
`timescale 1ns/100ps

module delimiterCrc8
(
  input  logic                   macCoreTxClk,
  input  logic                   macCoreClkHardRst_n,
  input  logic                   macCoreTxClkSoftRst_n,
  input  logic                   seqActive,
  input  ampduDelimPkg::byteIdxT byteIdx,
  input  logic                   delimiterSent,
  input  logic                   mpIfTxFifoFull,
  input  ampduDelimPkg::byteT    delimByte,
  output ampduDelimPkg::byteT    crcByte
);

  ampduDelimPkg::byteT crcReg;
  ampduDelimPkg::byteT crcNext;
  // Byte 0 or byte 1 accepted this cycle
  logic                crcFold;

  assign crcFold = !mpIfTxFifoFull && (byteIdx < 2'd2);

  // One byte per step, polynomial x8+x2+x+1
  // Data enters LSB first
  always_comb
  begin
    crcNext[0] = delimByte[0] ^ delimByte[1] ^ delimByte[7] ^ crcReg[0] ^ crcReg[6] ^ crcReg[7];
    crcNext[1] = delimByte[1] ^ delimByte[6] ^ delimByte[7] ^ crcReg[0] ^ crcReg[1] ^ crcReg[6];
    crcNext[2] = delimByte[1] ^ delimByte[5] ^ delimByte[6] ^ delimByte[7] ^
                 crcReg[0] ^ crcReg[1] ^ crcReg[2] ^ crcReg[6];
    crcNext[3] = delimByte[0] ^ delimByte[4] ^ delimByte[5] ^ delimByte[6] ^
                 crcReg[1] ^ crcReg[2] ^ crcReg[3] ^ crcReg[7];
    crcNext[4] = delimByte[3] ^ delimByte[4] ^ delimByte[5] ^ crcReg[2] ^ crcReg[3] ^ crcReg[4];
    crcNext[5] = delimByte[2] ^ delimByte[3] ^ delimByte[4] ^ crcReg[3] ^ crcReg[4] ^ crcReg[5];
    crcNext[6] = delimByte[1] ^ delimByte[2] ^ delimByte[3] ^ crcReg[4] ^ crcReg[5] ^ crcReg[6];
    crcNext[7] = delimByte[0] ^ delimByte[1] ^ delimByte[2] ^ crcReg[5] ^ crcReg[6] ^ crcReg[7];
  end

  // Preset between requests and after each signature byte
  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      crcReg <= ampduDelimPkg::CRC_PRESET;
    else if (!macCoreTxClkSoftRst_n || !seqActive || delimiterSent)
      crcReg <= ampduDelimPkg::CRC_PRESET;
    else if (crcFold)
      crcReg <= crcNext;
  end

  // Complement, MSB of the register goes out as bit 0
  always_comb
  begin
    for (int i = 0; i < 8; i++)
      crcByte[i] = ~crcReg[7-i];
  end

endmodule

// ==== hdl/txByteSequencer.sv ====
// Byte sequencer that paces FIFO writes and tracks the byte position under back-pressure
`timescale 1ns/100ps

module txByteSequencer
(
  input  logic                   macCoreTxClk,
  input  logic                   macCoreClkHardRst_n,
  input  logic                   macCoreTxClkSoftRst_n,
  input  logic                   aMPDUDelimiterStart_p,
  input  logic                   aMPDUPaddingStart_p,
  input  logic                   aMPDUDelimiterDone_p,
  input  logic                   aMPDUPaddingDone_p,
  input  logic                   mpIfTxFifoFull,
  output ampduDelimPkg::byteIdxT byteIdx,
  output logic                   seqActive,
  output logic                   delimiterSent,
  output logic                   aMPDUDelimiterWriteEn
);

  // Set by a start pulse, cleared by a done pulse
  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      seqActive <= 1'b0;
    else if (!macCoreTxClkSoftRst_n || aMPDUDelimiterDone_p || aMPDUPaddingDone_p)
      seqActive <= 1'b0;
    else if (aMPDUDelimiterStart_p || aMPDUPaddingStart_p)
      seqActive <= 1'b1;
  end

  // Byte index, frozen while the FIFO is full
  // Wraps from 3 to 0 between back-to-back delimiters
  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      byteIdx <= '0;
    else if (!macCoreTxClkSoftRst_n || !seqActive)
      byteIdx <= '0;
    else if (!mpIfTxFifoFull)
      byteIdx <= byteIdx + 2'd1;
  end

  // One write per unstalled active cycle
  assign aMPDUDelimiterWriteEn = seqActive && !mpIfTxFifoFull;

  // Signature byte accepted by the FIFO
  assign delimiterSent = aMPDUDelimiterWriteEn &&
                         (byteIdx == ampduDelimPkg::LAST_DELIM_BYTE);

endmodule

// ==== hdl/delimiterCtrlFsm.sv ====
// Controller FSM that sequences blank delimiters, the real delimiter and padding runs
`timescale 1ns/100ps

module delimiterCtrlFsm
(
  input  logic                      macCoreTxClk,
  input  logic                      macCoreClkHardRst_n,
  input  logic                      macCoreTxClkSoftRst_n,
  input  logic                      aMPDUDelimiterStart_p,
  input  logic                      aMPDUPaddingStart_p,
  input  logic                      addBlankDelimiter,
  input  ampduDelimPkg::blankCountT nBlankMDelimiters,
  input  logic                      delimiterSent,
  input  logic                      paddingSent,
  output ampduDelimPkg::delimFsmT   fsmState,
  output logic                      aMPDUDelimiterDone_p,
  output logic                      aMPDUPaddingDone_p
);

  ampduDelimPkg::delimFsmT   fsmNext;
  // Blank delimiters already written
  ampduDelimPkg::blankCountT nBlankSent;
  // Current delimiter is the final blank one
  logic                      lastBlank;

  assign lastBlank = (nBlankSent == (nBlankMDelimiters - 10'd1));

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      fsmState <= ampduDelimPkg::IDLE;
    else if (!macCoreTxClkSoftRst_n)
      fsmState <= ampduDelimPkg::IDLE;
    else
      fsmState <= fsmNext;
  end

  ////////////////////
  // Next state
  ////////////////////

  always_comb
  begin
    fsmNext = fsmState;
    case (fsmState)
      ampduDelimPkg::IDLE:
      begin
        // Padding wins over a delimiter request
        if (aMPDUPaddingStart_p)
          fsmNext = ampduDelimPkg::INSERT_PAD;
        else if (aMPDUDelimiterStart_p && addBlankDelimiter)
          fsmNext = ampduDelimPkg::INSERT_BLANKDEL;
        else if (aMPDUDelimiterStart_p)
          fsmNext = ampduDelimPkg::INSERT_DEL;
      end
      ampduDelimPkg::INSERT_BLANKDEL:
      begin
        // Real delimiter follows the last blank one
        if (delimiterSent && lastBlank)
          fsmNext = ampduDelimPkg::INSERT_DEL;
      end
      ampduDelimPkg::INSERT_DEL:
      begin
        if (delimiterSent)
          fsmNext = ampduDelimPkg::IDLE;
      end
      ampduDelimPkg::INSERT_PAD:
      begin
        if (paddingSent)
          fsmNext = ampduDelimPkg::IDLE;
      end
      default:
        fsmNext = ampduDelimPkg::IDLE;
    endcase
  end

  ////////////////////
  // Blank delimiter count
  ////////////////////

  // Only counts inside the blank phase
  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      nBlankSent <= '0;
    else if (!macCoreTxClkSoftRst_n || (fsmState != ampduDelimPkg::INSERT_BLANKDEL))
      nBlankSent <= '0;
    else if (delimiterSent)
      nBlankSent <= nBlankSent + 10'd1;
  end

  // Done pulses towards the transmit controller
  assign aMPDUDelimiterDone_p = delimiterSent && (fsmState == ampduDelimPkg::INSERT_DEL);
  assign aMPDUPaddingDone_p   = paddingSent && (fsmState == ampduDelimPkg::INSERT_PAD);

endmodule

// ==== hdl/ampduDelimPkg.sv ====
// Shared widths, controller states and delimiter constants for the A-MPDU delimiter formatter
package ampduDelimPkg;

  ////////////////////
  // Data widths
  ////////////////////

  // One byte towards the MAC-PHY FIFO
  typedef logic [7:0]  byteT;

  // MPDU length from the parameter cache
  // Only bits 13:0 reach the delimiter
  typedef logic [15:0] frameLenT;

  // Byte position inside a delimiter or a padding run
  typedef logic [1:0]  byteIdxT;

  // Number of blank delimiters to insert
  typedef logic [9:0]  blankCountT;

  // Transmit modulation format code
  typedef logic [2:0]  formatModT;

  ////////////////////
  // Controller states
  ////////////////////

  typedef enum logic [1:0] {
    IDLE            = 2'd0,
    INSERT_BLANKDEL = 2'd1,
    INSERT_DEL      = 2'd2,
    INSERT_PAD      = 2'd3
  } delimFsmT;

  ////////////////////
  // Delimiter constants
  ////////////////////

  // Last byte of every delimiter
  localparam byteT      DEL_SIGNATURE   = 8'h4E;
  // VHT format selects the VHT byte 0 layout
  localparam formatModT FORMAT_VHT      = 3'b100;
  // CRC register start value
  localparam byteT      CRC_PRESET      = 8'hFF;
  // Index of the signature byte
  localparam byteIdxT   LAST_DELIM_BYTE = 2'd3;

endpackage
